/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module extrema_tb \
		-f list.f -o extrema_sim
	./obj_dir/extrema_sim | tee sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log || \
		! grep -qF '*** TEST PASSED ***' sim.log; then \
		echo "simulation reported a failure"; exit 1; fi

lint:
	verilator --lint-only -Wall --top-module extrema_detector \
		common/dog_pkg.sv common/pixel_read_if.sv extrema/pixel_reader.sv \
		extrema/neighborhood_window.sv extrema/extremum_compare.sv \
		extrema/scan_controller.sv src/extrema_detector.sv

clean:
	rm -rf obj_dir sim.log

/* bench/extrema_checker.sv */
`timescale 1ns/1ns

module extrema_checker #(
  parameter int DIMENSION = 4,
  localparam int COORD_W = $clog2(DIMENSION),
  localparam int ADDR_W = $clog2(DIMENSION * DIMENSION)
) (
  input logic               clk,
  input logic               rst_in,
  input logic               key_wea,
  input logic [2*COORD_W:0] key_out,
  input logic               done,
  input logic               reader_done,
  input logic [ADDR_W-1:0]  first_address,
  input logic [ADDR_W-1:0]  second_address
);

  int failures = 0;

  // the end marker is a zero word written together with done
  assert property (@(posedge clk) disable iff (rst_in) done |-> key_wea && key_out == '0)
    else begin
      $error("done came without a zero end-marker write");
      failures++;
    end

  assert property (@(posedge clk) disable iff (rst_in) done |=> !done)
    else begin
      $error("done stayed high for two cycles");
      failures++;
    end

  assert property (@(posedge clk) disable iff (rst_in) reader_done |=> !reader_done)
    else begin
      $error("reader done stayed high for two cycles");
      failures++;
    end

  // addresses are undefined until the first request
  assert property (@(posedge clk) disable iff (rst_in)
    !$isunknown(first_address) |-> int'(first_address) < DIMENSION * DIMENSION)
    else begin
      $error("first address %0d outside the layer", first_address);
      failures++;
    end

  // both layers are read at one shared address
  assert property (@(posedge clk) disable iff (rst_in)
    !$isunknown(first_address) |-> second_address == first_address)
    else begin
      $error("second address %0d differs from first address %0d",
             second_address, first_address);
      failures++;
    end

endmodule

/* bench/extrema_tb.sv */
`timescale 1ns/1ns

module extrema_tb;
  import dog_pkg::*;

  localparam int DIMENSION = 4;
  localparam int COORD_W = $clog2(DIMENSION);
  localparam int ADDR_W = $clog2(DIMENSION * DIMENSION);
  localparam int KEY_W = 2 * COORD_W + 1;
  localparam int PIXELS = DIMENSION * DIMENSION;
  // record: behaviour, retrigger flag, key count, key slots, first layer, second layer
  localparam int MAX_KEYS = 8;
  localparam int REC_WORDS = 3 + MAX_KEYS + 2 * PIXELS;
  localparam int MAX_RUNS = 10;
  localparam int TIMEOUT_CYCLES = 1000;

  logic              clk;
  logic              rst_in;
  logic              enable;
  logic [ADDR_W-1:0] first_address;
  logic [ADDR_W-1:0] second_address;
  dog_pixel_t        first_data;
  dog_pixel_t        second_data;
  logic              key_wea;
  logic [KEY_W-1:0]  key_out;
  logic              done;

  logic [15:0] vectors [1 + MAX_RUNS * REC_WORDS];
  dog_pixel_t  first_mem [PIXELS];
  dog_pixel_t  second_mem [PIXELS];
  dog_pixel_t  first_pipe [READ_LATENCY] = '{default: '0};
  dog_pixel_t  second_pipe [READ_LATENCY] = '{default: '0};

  logic [KEY_W-1:0] keys [$];
  int               run_errors;
  int               error_count;
  int               runs_passed;
  int               runs_failed;
  bit               timed_out;

  extrema_detector #(.DIMENSION(DIMENSION)) i_extrema_detector (
    .clk           (clk),
    .rst_in        (rst_in),
    .enable        (enable),
    .first_address (first_address),
    .second_address(second_address),
    .first_data    (first_data),
    .second_data   (second_data),
    .key_wea       (key_wea),
    .key_out       (key_out),
    .done          (done)
  );

  bind extrema_detector extrema_checker #(.DIMENSION(DIMENSION)) i_extrema_checker (
    .clk           (clk),
    .rst_in        (rst_in),
    .key_wea       (key_wea),
    .key_out       (key_out),
    .done          (done),
    .reader_done   (read_bus.done),
    .first_address (first_address),
    .second_address(second_address)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // both layer memories answer READ_LATENCY cycles after the address
  always @(posedge clk) begin
    first_pipe[0]  <= first_mem[first_address];
    second_pipe[0] <= second_mem[second_address];
    for (int i = 1; i < READ_LATENCY; i++) begin
      first_pipe[i]  <= first_pipe[i-1];
      second_pipe[i] <= second_pipe[i-1];
    end
  end

  assign first_data  = first_pipe[READ_LATENCY-1];
  assign second_data = second_pipe[READ_LATENCY-1];

  task automatic load_layers(input int base);
    for (int i = 0; i < PIXELS; i++) begin
      first_mem[i]  = dog_pixel_t'(vectors[base + 3 + MAX_KEYS + i][8:0]);
      second_mem[i] = dog_pixel_t'(vectors[base + 3 + MAX_KEYS + PIXELS + i][8:0]);
    end
  endtask

  // start one scan and collect keypoint words until done
  task automatic run_scan(input bit retrigger);
    int cycles;
    bit finished;
    bit pulse_enable;
    keys.delete();
    cycles       = 0;
    finished     = 1'b0;
    pulse_enable = 1'b0;
    @(posedge clk);
    enable <= 1'b1;
    while (!finished && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      // optional second enable pulse while the scan runs
      enable       <= pulse_enable;
      pulse_enable = 1'b0;
      @(negedge clk);
      if (done) begin
        finished = 1'b1;
        if (!key_wea) begin
          $display("** Error at %0t: key_wea = %b, expected 1 with done", $time, key_wea);
          run_errors++;
        end
        if (key_out != '0) begin
          $display("** Error at %0t: key_out = %h, expected 00 with done", $time, key_out);
          run_errors++;
        end
      end else if (key_wea) begin
        keys.push_back(key_out);
        // enable again once a keypoint is out, a restart would repeat it
        pulse_enable = retrigger;
      end
      cycles++;
    end
    if (!finished) begin
      timed_out = 1'b1;
    end
  endtask

  task automatic check_keys(input int base);
    int               expected_count;
    logic [KEY_W-1:0] expected;
    expected_count = int'(vectors[base + 2]);
    if (keys.size() != expected_count) begin
      $display("** Error at %0t: key_wea count = %0d, expected %0d",
               $time, keys.size(), expected_count);
      run_errors++;
    end
    for (int i = 0; i < expected_count && i < keys.size(); i++) begin
      expected = vectors[base + 3 + i][KEY_W-1:0];
      if (keys[i] != expected) begin
        $display("** Error at %0t: key_out word %0d = %h, expected %h",
                 $time, i, keys[i], expected);
        run_errors++;
      end
    end
  endtask

  initial begin : main
    int run_count;
    int base;
    int behaviour;
    int assertion_failures;
    rst_in      = 1'b1;
    enable      = 1'b0;
    error_count = 0;
    runs_passed = 0;
    runs_failed = 0;
    timed_out   = 1'b0;
    $readmemh("bench/extrema_vectors.txt", vectors);
    run_count = int'(vectors[0]);
    repeat (5) @(posedge clk);
    rst_in <= 1'b0;
    for (int run = 0; run < run_count && run < MAX_RUNS && !timed_out; run++) begin
      base       = 1 + run * REC_WORDS;
      behaviour  = int'(vectors[base]);
      run_errors = 0;
      load_layers(base);
      run_scan(vectors[base + 1] != 16'h0);
      if (timed_out) begin
        $display("run %0d, behaviour %0d: no done within %0d cycles",
                 run + 1, behaviour, TIMEOUT_CYCLES);
        runs_failed++;
      end else begin
        check_keys(base);
        if (run_errors == 0) begin
          $display("run %0d, behaviour %0d: %0d keypoints, pass", run + 1, behaviour, keys.size());
          runs_passed++;
        end else begin
          $display("run %0d, behaviour %0d: %0d errors, fail", run + 1, behaviour, run_errors);
          runs_failed++;
        end
      end
      error_count += run_errors;
    end
    if (runs_passed + runs_failed == 0) begin
      $display("the vector file holds no runs");
    end
    assertion_failures = i_extrema_detector.i_extrema_checker.failures;
    $display("runs passed: %0d, runs failed: %0d, errors: %0d, assertion failures: %0d",
             runs_passed, runs_failed, error_count, assertion_failures);
    if (runs_passed > 0 && runs_failed == 0 && error_count == 0 && !timed_out &&
        assertion_failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* bench/extrema_vectors.txt */
// first word: number of runs; then per run three lines
// behaviour retrigger key_count key0..key7 / first layer row-major / second layer row-major
08
// flat layers
1 0 0 00 00 00 00 00 00 00 00
010 010 010 010 010 010 010 010 010 010 010 010 010 010 010 010
010 010 010 010 010 010 010 010 010 010 010 010 010 010 010 010
// positive peak in the first layer at (1,2)
2 0 1 0C 00 00 00 00 00 00 00
010 010 010 010 010 010 010 010 010 050 010 010 010 010 010 010
010 010 010 010 010 010 010 010 010 010 010 010 010 010 010 010
// negative dip in the second layer at (2,1), one negative neighbour
3 0 1 13 00 00 00 00 00 00 00
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 1EC 000 000 000 000 1FB 000 000 000 000
// both layers at (2,2)
4 0 2 14 15 00 00 00 00 00 00
008 008 008 008 008 008 008 008 008 008 040 008 008 008 008 008
008 008 008 008 008 008 008 008 008 008 1C0 008 008 008 008 008
// first layer max at (1,1) and min at (2,2)
4 0 2 0A 14 00 00 00 00 00 00
000 000 000 000 000 040 000 000 000 000 1C0 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
// centre at (1,1) ties with (0,0)
5 0 0 00 00 00 00 00 00 00 00
040 000 000 000 000 040 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
// back-to-back runs, the second with enable raised mid-scan
6 0 1 0B 00 00 00 00 00 00 00
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 030 000 000 000 000 000 000 000 000 000 000
6 1 1 12 00 00 00 00 00 00 00
002 002 002 002 002 002 1F8 002 002 002 002 002 002 002 002 002
002 002 002 002 002 002 002 002 002 002 002 002 002 002 002 002

/* common/dog_pkg.sv */
package dog_pkg;

  // signed difference of two 8-bit grey levels
  typedef logic signed [8:0] dog_pixel_t;

  // cycles from an address at the memories to valid data
  localparam int READ_LATENCY = 2;

  // one centre plus eight neighbours per layer
  localparam int NBR_COUNT = 9;

  // fetch order of a full load, values double as window slot indices
  typedef enum logic [3:0] {
    TOP    = 4'd0,
    TOPR   = 4'd1,
    RIGHT  = 4'd2,
    BOTR   = 4'd3,
    BOT    = 4'd4,
    BOTL   = 4'd5,
    LEFT   = 4'd6,
    TOPL   = 4'd7,
    MIDDLE = 4'd8,
    NONE   = 4'd9
  } nbr_pos_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    CHECK,
    WRITE_SECOND,
    ADVANCE,
    FINISH
  } scan_state_t;

endpackage

/* common/pixel_read_if.sv */
`timescale 1ns/1ns

interface pixel_read_if #(
  parameter int DIMENSION = 4
);
  import dog_pkg::*;

  localparam int COORD_W = $clog2(DIMENSION);

  // one-cycle request for the pixel pair at (x, y)
  logic               req;
  logic [COORD_W-1:0] x;
  logic [COORD_W-1:0] y;

  // done pulses when both samples are held
  logic       done;
  dog_pixel_t first_value;
  dog_pixel_t second_value;

  modport requester (
    output req,
    output x,
    output y,
    input  done,
    input  first_value,
    input  second_value
  );

  modport reader (
    input  req,
    input  x,
    input  y,
    output done,
    output first_value,
    output second_value
  );

endinterface

/* extrema/extremum_compare.sv */
`timescale 1ns/1ns

module extremum_compare (
  input  dog_pkg::dog_pixel_t [dog_pkg::NBR_COUNT-1:0] window_own,
  input  dog_pkg::dog_pixel_t [dog_pkg::NBR_COUNT-1:0] window_other,
  output logic                                         is_extremum
);
  import dog_pkg::*;

  // strict signed test against 8 own neighbours and all 9 of the other layer
  always_comb begin : compare_all
    dog_pixel_t centre;
    dog_pixel_t own_nbr;
    dog_pixel_t other_nbr;
    logic       above_all;
    logic       below_all;

    centre    = window_own[MIDDLE];
    above_all = 1'b1;
    below_all = 1'b1;
    for (int i = 0; i < NBR_COUNT; i++) begin
      own_nbr   = window_own[i];
      other_nbr = window_other[i];
      // the centre is not its own neighbour
      if (i != int'(MIDDLE)) begin
        above_all = above_all && (centre > own_nbr);
        below_all = below_all && (centre < own_nbr);
      end
      above_all = above_all && (centre > other_nbr);
      below_all = below_all && (centre < other_nbr);
    end
    // a tie with any neighbour rules out both
    is_extremum = above_all || below_all;
  end

endmodule

/* extrema/neighborhood_window.sv */
`timescale 1ns/1ns

module neighborhood_window #(
  parameter int DIMENSION = 4,
  localparam int COORD_W = $clog2(DIMENSION)
) (
  input  logic                clk,
  input  logic                rst_in,
  input  logic                load_full,
  input  logic                load_shift,
  input  logic [COORD_W-1:0]  x,
  input  logic [COORD_W-1:0]  y,
  output logic                loaded,
  pixel_read_if.requester     rd,
  output dog_pkg::dog_pixel_t [dog_pkg::NBR_COUNT-1:0] first_window,
  output dog_pkg::dog_pixel_t [dog_pkg::NBR_COUNT-1:0] second_window
);
  import dog_pkg::*;

  typedef dog_pixel_t [NBR_COUNT-1:0] window_t;

  nbr_pos_t fetch_pos;
  logic     pending;
  logic     shift_mode;
  logic     last_fetch;

  // slide one column left, the right column is refetched afterwards
  function automatic window_t shift_left(window_t w);
    window_t s;
    s         = w;
    s[TOPL]   = w[TOP];
    s[LEFT]   = w[MIDDLE];
    s[BOTL]   = w[BOT];
    s[TOP]    = w[TOPR];
    s[MIDDLE] = w[RIGHT];
    s[BOT]    = w[BOTR];
    return s;
  endfunction

  // one request per slot, never while a read is outstanding
  assign rd.req = (fetch_pos != NONE) && !pending;

  // a shift ends at BOTR, a full load at MIDDLE
  assign last_fetch = (fetch_pos == MIDDLE) || (shift_mode && fetch_pos == BOTR);

  // neighbour coordinates relative to the current centre
  always_comb begin
    rd.x = x;
    rd.y = y;
    case (fetch_pos)
      TOP: begin
        rd.y = y - 1'b1;
      end
      TOPR: begin
        rd.x = x + 1'b1;
        rd.y = y - 1'b1;
      end
      RIGHT: begin
        rd.x = x + 1'b1;
      end
      BOTR: begin
        rd.x = x + 1'b1;
        rd.y = y + 1'b1;
      end
      BOT: begin
        rd.y = y + 1'b1;
      end
      BOTL: begin
        rd.x = x - 1'b1;
        rd.y = y + 1'b1;
      end
      LEFT: begin
        rd.x = x - 1'b1;
      end
      TOPL: begin
        rd.x = x - 1'b1;
        rd.y = y - 1'b1;
      end
      default: begin
        rd.x = x;
        rd.y = y;
      end
    endcase
  end

  // fetch sequencing
  always_ff @(posedge clk) begin
    if (rst_in) begin
      fetch_pos  <= NONE;
      pending    <= 1'b0;
      shift_mode <= 1'b0;
      loaded     <= 1'b0;
    end else begin
      loaded <= 1'b0;
      if (load_full) begin
        fetch_pos  <= TOP;
        shift_mode <= 1'b0;
      end else if (load_shift) begin
        fetch_pos  <= TOPR;
        shift_mode <= 1'b1;
      end else if (rd.req) begin
        pending <= 1'b1;
      end else if (rd.done) begin
        pending <= 1'b0;
        if (last_fetch) begin
          fetch_pos <= NONE;
          loaded    <= 1'b1;
        end else begin
          fetch_pos <= nbr_pos_t'(fetch_pos + 4'd1);
        end
      end
    end
  end

  // window registers for both layers
  always_ff @(posedge clk) begin
    if (load_shift) begin
      first_window  <= shift_left(first_window);
      second_window <= shift_left(second_window);
    end else if (rd.done) begin
      first_window[fetch_pos]  <= rd.first_value;
      second_window[fetch_pos] <= rd.second_value;
    end
  end

endmodule

/* extrema/pixel_reader.sv */
`timescale 1ns/1ns

module pixel_reader #(
  parameter int DIMENSION = 4,
  localparam int ADDR_W = $clog2(DIMENSION * DIMENSION)
) (
  input  logic                clk,
  input  logic                rst_in,
  pixel_read_if.reader        rd,
  output logic [ADDR_W-1:0]   first_address,
  output logic [ADDR_W-1:0]   second_address,
  input  dog_pkg::dog_pixel_t first_data,
  input  dog_pkg::dog_pixel_t second_data
);
  import dog_pkg::*;

  logic                                busy;
  logic [$clog2(READ_LATENCY + 1)-1:0] wait_count;

  // control: accept a request, count out the memory latency, pulse done
  always_ff @(posedge clk) begin
    if (rst_in) begin
      busy       <= 1'b0;
      wait_count <= '0;
      rd.done    <= 1'b0;
    end else begin
      rd.done <= 1'b0;
      if (!busy && rd.req) begin
        busy       <= 1'b1;
        wait_count <= '0;
      end else if (busy) begin
        if (wait_count == READ_LATENCY) begin
          busy    <= 1'b0;
          rd.done <= 1'b1;
        end else begin
          wait_count <= wait_count + 1'b1;
        end
      end
    end
  end

  // both layers share one address, row-major
  always_ff @(posedge clk) begin
    if (!busy && rd.req) begin
      first_address  <= ADDR_W'(rd.y * DIMENSION + rd.x);
      second_address <= ADDR_W'(rd.y * DIMENSION + rd.x);
    end
  end

  // samples are stable by the last latency cycle
  always_ff @(posedge clk) begin
    if (busy && wait_count == READ_LATENCY) begin
      rd.first_value  <= first_data;
      rd.second_value <= second_data;
    end
  end

endmodule

/* extrema/scan_controller.sv */
`timescale 1ns/1ns

module scan_controller #(
  parameter int DIMENSION = 4,
  localparam int COORD_W = $clog2(DIMENSION)
) (
  input  logic               clk,
  input  logic               rst_in,
  input  logic               enable,
  input  logic               is_extremum_first,
  input  logic               is_extremum_second,
  input  logic               loaded,
  output logic               load_full,
  output logic               load_shift,
  output logic [COORD_W-1:0] x,
  output logic [COORD_W-1:0] y,
  output logic               key_wea,
  output logic [2*COORD_W:0] key_out,
  output logic               done
);
  import dog_pkg::*;

  // last interior coordinate in both directions
  localparam logic [COORD_W-1:0] LAST = COORD_W'(DIMENSION - 2);

  scan_state_t state;

  always_ff @(posedge clk) begin
    if (rst_in) begin
      state      <= IDLE;
      x          <= COORD_W'(1);
      y          <= COORD_W'(1);
      load_full  <= 1'b0;
      load_shift <= 1'b0;
      key_wea    <= 1'b0;
      key_out    <= '0;
      done       <= 1'b0;
    end else begin
      load_full  <= 1'b0;
      load_shift <= 1'b0;
      key_wea    <= 1'b0;
      done       <= 1'b0;
      case (state)
        IDLE: begin
          // enable only counts here, a running scan ignores it
          if (enable) begin
            x         <= COORD_W'(1);
            y         <= COORD_W'(1);
            load_full <= 1'b1;
            state     <= LOAD;
          end
        end
        LOAD: begin
          if (loaded) begin
            state <= CHECK;
          end
        end
        CHECK: begin
          if (is_extremum_first) begin
            key_wea <= 1'b1;
            key_out <= {x, y, 1'b0};
            // second layer hit goes out on the next cycle
            state   <= is_extremum_second ? WRITE_SECOND : ADVANCE;
          end else if (is_extremum_second) begin
            key_wea <= 1'b1;
            key_out <= {x, y, 1'b1};
            state   <= ADVANCE;
          end else begin
            state <= ADVANCE;
          end
        end
        WRITE_SECOND: begin
          key_wea <= 1'b1;
          key_out <= {x, y, 1'b1};
          state   <= ADVANCE;
        end
        ADVANCE: begin
          if (x < LAST) begin
            x          <= x + 1'b1;
            load_shift <= 1'b1;
            state      <= LOAD;
          end else if (y < LAST) begin
            // new row needs all nine neighbours again
            x         <= COORD_W'(1);
            y         <= y + 1'b1;
            load_full <= 1'b1;
            state     <= LOAD;
          end else begin
            state <= FINISH;
          end
        end
        FINISH: begin
          // end marker
          key_wea <= 1'b1;
          key_out <= '0;
          done    <= 1'b1;
          state   <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

/* list.f */
common/dog_pkg.sv
common/pixel_read_if.sv
extrema/pixel_reader.sv
extrema/neighborhood_window.sv
extrema/extremum_compare.sv
extrema/scan_controller.sv
src/extrema_detector.sv
bench/extrema_checker.sv
bench/extrema_tb.sv

/* src/extrema_detector.sv */
`timescale 1ns/1ns

module extrema_detector #(
  parameter int DIMENSION = 4,
  localparam int COORD_W = $clog2(DIMENSION),
  localparam int ADDR_W = $clog2(DIMENSION * DIMENSION)
) (
  input  logic                clk,
  input  logic                rst_in,
  input  logic                enable,
  output logic [ADDR_W-1:0]   first_address,
  output logic [ADDR_W-1:0]   second_address,
  input  dog_pkg::dog_pixel_t first_data,
  input  dog_pkg::dog_pixel_t second_data,
  output logic                key_wea,
  output logic [2*COORD_W:0]  key_out,
  output logic                done
);
  import dog_pkg::*;

  logic               load_full;
  logic               load_shift;
  logic               loaded;
  logic [COORD_W-1:0] x;
  logic [COORD_W-1:0] y;
  logic               is_extremum_first;
  logic               is_extremum_second;

  dog_pixel_t [NBR_COUNT-1:0] first_window;
  dog_pixel_t [NBR_COUNT-1:0] second_window;

  pixel_read_if #(.DIMENSION(DIMENSION)) read_bus ();

  scan_controller #(.DIMENSION(DIMENSION)) i_scan_controller (
    .clk               (clk),
    .rst_in            (rst_in),
    .enable            (enable),
    .is_extremum_first (is_extremum_first),
    .is_extremum_second(is_extremum_second),
    .loaded            (loaded),
    .load_full         (load_full),
    .load_shift        (load_shift),
    .x                 (x),
    .y                 (y),
    .key_wea           (key_wea),
    .key_out           (key_out),
    .done              (done)
  );

  neighborhood_window #(.DIMENSION(DIMENSION)) i_neighborhood_window (
    .clk          (clk),
    .rst_in       (rst_in),
    .load_full    (load_full),
    .load_shift   (load_shift),
    .x            (x),
    .y            (y),
    .loaded       (loaded),
    .rd           (read_bus.requester),
    .first_window (first_window),
    .second_window(second_window)
  );

  pixel_reader #(.DIMENSION(DIMENSION)) i_pixel_reader (
    .clk           (clk),
    .rst_in        (rst_in),
    .rd            (read_bus.reader),
    .first_address (first_address),
    .second_address(second_address),
    .first_data    (first_data),
    .second_data   (second_data)
  );

  // each layer's centre is tested against its own window and the other layer
  extremum_compare i_compare_first (
    .window_own  (first_window),
    .window_other(second_window),
    .is_extremum (is_extremum_first)
  );

  extremum_compare i_compare_second (
    .window_own  (second_window),
    .window_other(first_window),
    .is_extremum (is_extremum_second)
  );

endmodule
